// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_mmu
FILELIST   := compile.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
mmu_pkg.sv
mmu_req_stage.sv
pte_walker.sv
pte_checker.sv
mmu_top.sv
tb_pt_mem.sv
tb_mmu.sv

// ==== mmu_pkg.sv ====
package mmu_pkg;

    typedef enum logic [1:0] {
        acc_inst,
        acc_load,
        acc_store
    } access_t;

    // encodings follow the privileged spec, 2 is reserved
    typedef enum logic [1:0] {
        priv_u = 2'd0,
        priv_s = 2'd1,
        priv_m = 2'd3
    } priv_t;

    typedef enum logic [2:0] {
        idle,
        rd_l1_setup,
        rd_l1_access,
        rd_l0_setup,
        rd_l0_access,
        hand_off
    } walk_state_t;

    typedef enum logic [1:0] {
        flt_none,
        flt_page,
        flt_access
    } fault_t;

    // sv32 pte flag positions
    localparam int pte_v = 0;
    localparam int pte_r = 1;
    localparam int pte_w = 2;
    localparam int pte_x = 3;
    localparam int pte_u = 4;
    localparam int pte_a = 6; // bit 5 is G, unused here
    localparam int pte_d = 7;

    // mcause / scause values
    localparam logic [4:0] exc_inst_access  = 5'd1;
    localparam logic [4:0] exc_load_access  = 5'd5;
    localparam logic [4:0] exc_store_access = 5'd7;
    localparam logic [4:0] exc_inst_page    = 5'd12;
    localparam logic [4:0] exc_load_page    = 5'd13;
    localparam logic [4:0] exc_store_page   = 5'd15;

endpackage

// ==== mmu_req_stage.sv ====
module mmu_req_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    output logic             req_ready,
    input  logic [31:0]      req_va,
    input  mmu_pkg::access_t req_access,
    input  mmu_pkg::priv_t   req_priv,
    input  logic [31:0]      satp,
    input  logic             sum,
    output logic             rq_valid,
    input  logic             rq_ready,
    output logic [31:0]      rq_va,
    output mmu_pkg::access_t rq_access,
    output mmu_pkg::priv_t   rq_priv,
    output logic             rq_sum,
    output logic [21:0]      rq_root_ppn,
    output logic             rq_bare
);
    import mmu_pkg::*;

    logic take;
    logic bare_next;

    // free slot, or the held entry leaves this cycle
    assign req_ready = !rq_valid || rq_ready;
    assign take      = req_valid && req_ready;

    // satp.MODE clear is bare; M mode never translates
    assign bare_next = !satp[31] || (req_priv == priv_m);

    always_ff @(posedge clk) begin
        if (rst) begin
            rq_valid <= 1'b0;
        end else if (take) begin
            rq_valid <= 1'b1;
        end else if (rq_ready) begin
            rq_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rq_va       <= req_va;
            rq_access   <= req_access;
            rq_priv     <= req_priv;
            rq_sum      <= sum;
            rq_root_ppn <= satp[21:0]; // asid bits dropped
            rq_bare     <= bare_next;
        end
    end

endmodule

// ==== mmu_top.sv ====
module mmu_top #(
    parameter int pa_width = 34
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    output logic                req_ready,
    input  logic [31:0]         req_va,
    input  mmu_pkg::access_t    req_access,
    input  mmu_pkg::priv_t      req_priv,
    input  logic [31:0]         satp,
    input  logic                sum,
    output logic                resp_valid,
    input  logic                resp_ready,
    output logic [pa_width-1:0] resp_pa,
    output logic                resp_fault,
    output logic [4:0]          resp_cause,
    output logic [31:0]         resp_va,
    output logic [pa_width-1:0] paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    input  logic [31:0]         prdata,
    input  logic                pready,
    input  logic                pslverr
);
    import mmu_pkg::*;

    // request stage to walker
    logic        rq_valid;
    logic        rq_ready;
    logic [31:0] rq_va;
    access_t     rq_access;
    priv_t       rq_priv;
    logic        rq_sum;
    logic [21:0] rq_root_ppn;
    logic        rq_bare;

    // walker to checker
    logic        wk_valid;
    logic        wk_ready;
    logic [31:0] wk_va;
    access_t     wk_access;
    priv_t       wk_priv;
    logic        wk_sum;
    logic        wk_bare;
    logic [31:0] wk_pte;
    logic        wk_level;
    logic        wk_bus_err;

    mmu_req_stage i_req_stage (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_va      (req_va),
        .req_access  (req_access),
        .req_priv    (req_priv),
        .satp        (satp),
        .sum         (sum),
        .rq_valid    (rq_valid),
        .rq_ready    (rq_ready),
        .rq_va       (rq_va),
        .rq_access   (rq_access),
        .rq_priv     (rq_priv),
        .rq_sum      (rq_sum),
        .rq_root_ppn (rq_root_ppn),
        .rq_bare     (rq_bare)
    );

    pte_walker #(
        .pa_width (pa_width)
    ) i_walker (
        .clk         (clk),
        .rst         (rst),
        .rq_valid    (rq_valid),
        .rq_ready    (rq_ready),
        .rq_va       (rq_va),
        .rq_access   (rq_access),
        .rq_priv     (rq_priv),
        .rq_sum      (rq_sum),
        .rq_root_ppn (rq_root_ppn),
        .rq_bare     (rq_bare),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .wk_valid    (wk_valid),
        .wk_ready    (wk_ready),
        .wk_va       (wk_va),
        .wk_access   (wk_access),
        .wk_priv     (wk_priv),
        .wk_sum      (wk_sum),
        .wk_bare     (wk_bare),
        .wk_pte      (wk_pte),
        .wk_level    (wk_level),
        .wk_bus_err  (wk_bus_err)
    );

    pte_checker #(
        .pa_width (pa_width)
    ) i_checker (
        .clk        (clk),
        .rst        (rst),
        .wk_valid   (wk_valid),
        .wk_ready   (wk_ready),
        .wk_va      (wk_va),
        .wk_access  (wk_access),
        .wk_priv    (wk_priv),
        .wk_sum     (wk_sum),
        .wk_bare    (wk_bare),
        .wk_pte     (wk_pte),
        .wk_level   (wk_level),
        .wk_bus_err (wk_bus_err),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_pa    (resp_pa),
        .resp_fault (resp_fault),
        .resp_cause (resp_cause),
        .resp_va    (resp_va)
    );

endmodule

// ==== pte_checker.sv ====
module pte_checker #(
    parameter int pa_width = 34
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                wk_valid,
    output logic                wk_ready,
    input  logic [31:0]         wk_va,
    input  mmu_pkg::access_t    wk_access,
    input  mmu_pkg::priv_t      wk_priv,
    input  logic                wk_sum,
    input  logic                wk_bare,
    input  logic [31:0]         wk_pte,
    input  logic                wk_level,
    input  logic                wk_bus_err,
    output logic                resp_valid,
    input  logic                resp_ready,
    output logic [pa_width-1:0] resp_pa,
    output logic                resp_fault,
    output logic [4:0]          resp_cause,
    output logic [31:0]         resp_va
);
    import mmu_pkg::*;

    fault_t      fault;
    logic        take;
    logic        perm_ok;
    logic        priv_bad;
    logic        ptr_at_l0;
    logic        page_bad;
    logic [33:0] pa_full;
    logic [4:0]  cause;

    assign wk_ready = !resp_valid || resp_ready;
    assign take     = wk_valid && wk_ready;

    always_comb begin
        case (wk_access)
            acc_inst:  perm_ok = wk_pte[pte_x];
            acc_load:  perm_ok = wk_pte[pte_r];
            acc_store: perm_ok = wk_pte[pte_w] && wk_pte[pte_d]; // no hw dirty update
            default:   perm_ok = 1'b0;
        endcase
    end

    assign priv_bad  = (wk_priv == priv_u && !wk_pte[pte_u]) ||
                       (wk_priv == priv_s && wk_pte[pte_u] && !wk_sum);
    assign ptr_at_l0 = !wk_level && !wk_pte[pte_r] && !wk_pte[pte_w] && !wk_pte[pte_x];

    assign page_bad = !wk_pte[pte_v] || (wk_pte[pte_w] && !wk_pte[pte_r]) || ptr_at_l0 ||
                      priv_bad || !perm_ok || !wk_pte[pte_a];

    always_comb begin
        if (wk_bare) begin
            fault = flt_none;
        end else if (wk_bus_err) begin
            fault = flt_access; // pte contents meaningless
        end else if (page_bad) begin
            fault = flt_page;
        end else begin
            fault = flt_none;
        end
    end

    always_comb begin
        if (wk_bare) begin
            pa_full = {2'b00, wk_va};
        end else if (wk_level) begin
            pa_full = {wk_pte[31:20], wk_va[21:0]}; // 4 MiB superpage
        end else begin
            pa_full = {wk_pte[31:10], wk_va[11:0]};
        end
    end

    always_comb begin
        cause = 5'd0;
        case (fault)
            flt_access: begin
                case (wk_access)
                    acc_inst: cause = exc_inst_access;
                    acc_load: cause = exc_load_access;
                    default:  cause = exc_store_access;
                endcase
            end
            flt_page: begin
                case (wk_access)
                    acc_inst: cause = exc_inst_page;
                    acc_load: cause = exc_load_page;
                    default:  cause = exc_store_page;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (take) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            resp_pa    <= (fault == flt_none) ? pa_full[pa_width-1:0] : '0;
            resp_fault <= (fault != flt_none);
            resp_cause <= cause;
            resp_va    <= wk_va;
        end
    end

endmodule

// ==== pte_walker.sv ====
module pte_walker #(
    parameter int pa_width = 34
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rq_valid,
    output logic                rq_ready,
    input  logic [31:0]         rq_va,
    input  mmu_pkg::access_t    rq_access,
    input  mmu_pkg::priv_t      rq_priv,
    input  logic                rq_sum,
    input  logic [21:0]         rq_root_ppn,
    input  logic                rq_bare,
    output logic [pa_width-1:0] paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    input  logic [31:0]         prdata,
    input  logic                pready,
    input  logic                pslverr,
    output logic                wk_valid,
    input  logic                wk_ready,
    output logic [31:0]         wk_va,
    output mmu_pkg::access_t    wk_access,
    output mmu_pkg::priv_t      wk_priv,
    output logic                wk_sum,
    output logic                wk_bare,
    output logic [31:0]         wk_pte,
    output logic                wk_level,
    output logic                wk_bus_err
);
    import mmu_pkg::*;

    walk_state_t state;

    logic [33:0] l1_addr; // full sv32 physical address
    logic [33:0] l0_addr;
    logic        is_pointer;

    assign l1_addr = {rq_root_ppn, rq_va[31:22], 2'b00};
    assign l0_addr = {prdata[31:10], wk_va[21:12], 2'b00}; // next table from l1 data

    // valid with no leaf permissions means next level
    assign is_pointer = prdata[pte_v] && !prdata[pte_r] && !prdata[pte_w] && !prdata[pte_x];

    assign rq_ready = (state == idle);
    assign wk_valid = (state == hand_off);

    // apb outputs decoded from state, bare requests never select the slave
    assign psel    = !wk_bare && (state == rd_l1_setup || state == rd_l1_access ||
                                  state == rd_l0_setup || state == rd_l0_access);
    assign penable = (state == rd_l1_access) || (state == rd_l0_access);
    assign pwrite  = 1'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (rq_valid) begin
                        state <= rd_l1_setup;
                    end
                end
                rd_l1_setup: begin
                    state <= wk_bare ? hand_off : rd_l1_access; // bare takes one bubble
                end
                rd_l1_access: begin
                    if (pready) begin
                        state <= (!pslverr && is_pointer) ? rd_l0_setup : hand_off;
                    end
                end
                rd_l0_setup: begin
                    state <= rd_l0_access;
                end
                rd_l0_access: begin
                    if (pready) begin
                        state <= hand_off;
                    end
                end
                hand_off: begin
                    if (wk_ready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (rq_valid) begin
                    wk_va      <= rq_va;
                    wk_access  <= rq_access;
                    wk_priv    <= rq_priv;
                    wk_sum     <= rq_sum;
                    wk_bare    <= rq_bare;
                    wk_pte     <= '0;
                    wk_level   <= 1'b0;
                    wk_bus_err <= 1'b0;
                    paddr      <= l1_addr[pa_width-1:0];
                end
            end
            rd_l1_access: begin
                if (pready) begin
                    wk_pte     <= prdata;
                    wk_level   <= 1'b1;
                    wk_bus_err <= pslverr;
                    paddr      <= l0_addr[pa_width-1:0]; // only used if we walk on
                end
            end
            rd_l0_access: begin
                if (pready) begin
                    wk_pte     <= prdata;
                    wk_level   <= 1'b0;
                    wk_bus_err <= pslverr;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== tb_mmu.sv ====
module tb_mmu;
    import mmu_pkg::*;

    localparam int          pa_width  = 34;
    localparam int          timeout   = 500;
    localparam logic [21:0] root      = 22'h00100;
    localparam logic [31:0] satp_sv32 = {1'b1, 9'h000, root};

    logic                clk = 1'b0;
    logic                rst;
    logic                req_valid;
    logic                req_ready;
    logic [31:0]         req_va;
    access_t             req_access;
    priv_t               req_priv;
    logic [31:0]         satp;
    logic                sum;
    logic                resp_valid;
    logic                resp_ready;
    logic [pa_width-1:0] resp_pa;
    logic                resp_fault;
    logic [4:0]          resp_cause;
    logic [31:0]         resp_va;
    logic [pa_width-1:0] paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;
    logic [3:0]          max_wait;
    logic                err_en;
    logic [pa_width-1:0] err_addr;

    logic [31:0] pt [logic [33:0]]; // shadow of the page tables for the model
    logic [33:0] exp_pa [$];
    logic        exp_fault [$];
    logic [4:0]  exp_cause [$];
    logic [31:0] exp_va [$];
    int          psel_cycles = 0;
    int          seed = 32'h950;

    mmu_top #(.pa_width(pa_width)) i_dut (.*);
    tb_pt_mem #(.pa_width(pa_width)) i_mem (.*);

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (psel) psel_cycles <= psel_cycles + 1;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic logic coin();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    task automatic map_word(input logic [33:0] addr, input logic [31:0] data);
        pt[addr] = data;
        i_mem.put_word(addr, data);
    endtask

    function automatic logic [31:0] read_pt(input logic [33:0] addr);
        return pt.exists(addr) ? pt[addr] : 32'h0;
    endfunction

    // sv32 walk and permission rules
    function automatic void ref_translate(input logic [31:0] va, input access_t acc,
                                          input priv_t prv, input logic [31:0] satp_v,
                                          input logic sum_v, output logic [33:0] pa,
                                          output logic flt, output logic [4:0] cause);
        logic [33:0] a;
        logic [31:0] pte;
        logic        lvl;
        logic        bus_err;
        logic        allowed;
        pa = '0;
        flt = 1'b0;
        cause = 5'd0;
        if (!satp_v[31] || prv == priv_m) begin
            pa = {2'b00, va};
            return;
        end
        a = {satp_v[21:0], va[31:22], 2'b00};
        bus_err = err_en && (a == err_addr);
        pte = read_pt(a);
        lvl = 1'b1;
        if (!bus_err && pte[0] && pte[3:1] == 3'b000) begin // pointer to the next level
            a = {pte[31:10], va[21:12], 2'b00};
            bus_err = err_en && (a == err_addr);
            pte = read_pt(a);
            lvl = 1'b0;
        end
        case (acc)
            acc_inst: allowed = pte[3];
            acc_load: allowed = pte[1];
            default:  allowed = pte[2] && pte[7];
        endcase
        if (bus_err) begin
            flt = 1'b1;
            cause = (acc == acc_inst) ? 5'd1 : (acc == acc_load) ? 5'd5 : 5'd7;
        end else if (!pte[0] || (pte[2] && !pte[1]) || (!lvl && pte[3:1] == 3'b000) ||
                     (prv == priv_u && !pte[4]) || (prv == priv_s && pte[4] && !sum_v) ||
                     !allowed || !pte[6]) begin
            flt = 1'b1;
            cause = (acc == acc_inst) ? 5'd12 : (acc == acc_load) ? 5'd13 : 5'd15;
        end else begin
            pa = lvl ? {pte[31:20], va[21:0]} : {pte[31:10], va[11:0]};
        end
    endfunction

    task automatic send_req(input logic [31:0] va, input access_t acc, input priv_t prv,
                            input logic [31:0] satp_v, input logic sum_v);
        logic [33:0] pa;
        logic        flt;
        logic [4:0]  cause;
        int          waited;
        ref_translate(va, acc, prv, satp_v, sum_v, pa, flt, cause);
        exp_pa.push_back(pa);
        exp_fault.push_back(flt);
        exp_cause.push_back(cause);
        exp_va.push_back(va);
        req_valid = 1'b1;
        req_va = va;
        req_access = acc;
        req_priv = prv;
        satp = satp_v;
        sum = sum_v;
        waited = 0;
        @(negedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > timeout) begin
                $display("timeout: request for va %h never accepted", va);
                abort_run();
            end
            @(negedge clk);
        end
        @(posedge clk); // transfer edge
        #1;
        req_valid = 1'b0;
    endtask

    task automatic check_resp();
        logic [33:0] pa;
        logic        flt;
        logic [4:0]  cause;
        logic [31:0] va;
        pa = exp_pa.pop_front();
        flt = exp_fault.pop_front();
        cause = exp_cause.pop_front();
        va = exp_va.pop_front();
        assert (resp_va == va && resp_fault == flt && resp_cause == cause && resp_pa == pa)
        else begin
            $display("MISMATCH at %0t: va %h fault %b cause %0d pa %h", $time,
                     resp_va, resp_fault, resp_cause, resp_pa);
            $display("MISMATCH at %0t: expected va %h fault %b cause %0d pa %h", $time,
                     va, flt, cause, pa);
            abort_run();
        end
    endtask

    task automatic collect(input int count, input logic rand_ready);
        int got;
        int waited;
        got = 0;
        waited = 0;
        while (got < count) begin
            @(negedge clk);
            if (resp_valid && resp_ready) begin
                check_resp();
                got++;
                waited = 0;
            end else begin
                waited++;
                if (waited > timeout) begin
                    $display("timeout: response %0d of %0d never arrived", got + 1, count);
                    abort_run();
                end
            end
            @(posedge clk);
            #1;
            resp_ready = rand_ready ? coin() : 1'b1;
        end
    endtask

    task automatic run_one(input logic [31:0] va, input access_t acc, input priv_t prv,
                           input logic sum_v);
        send_req(va, acc, prv, satp_sv32, sum_v);
        collect(1, 1'b0);
    endtask

    // untranslated path has a fixed 3 cycle latency
    task automatic bare_case(input logic [31:0] va, input access_t acc, input priv_t prv,
                             input logic [31:0] satp_v);
        int cycles;
        int psel_before;
        psel_before = psel_cycles;
        send_req(va, acc, prv, satp_v, 1'b0);
        cycles = 0;
        @(negedge clk);
        while (!resp_valid) begin
            cycles++;
            if (cycles > timeout) begin
                $display("timeout: no response for bare request va %h", va);
                abort_run();
            end
            @(negedge clk);
        end
        assert (cycles == 3) else begin
            $display("MISMATCH at %0t: bare latency %0d cycles, expected 3", $time, cycles);
            abort_run();
        end
        check_resp();
        assert (psel_cycles == psel_before) else begin
            $display("MISMATCH at %0t: apb selected during bare request", $time);
            abort_run();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic bare_mode();
        bare_case(32'hdead_beef, acc_load, priv_s, 32'h0000_1234);
        bare_case(32'h8000_0ffc, acc_store, priv_m, satp_sv32); // m mode ignores satp
    endtask

    task automatic translate_ok();
        map_word({root, 10'd1, 2'b00}, make_pte(22'h12345, 8'hcf)); // 4 MiB leaf
        map_word({root, 10'd2, 2'b00}, make_pte(22'h00200, 8'h01));
        map_word({22'h00200, 10'd3, 2'b00}, make_pte(22'h3abcd, 8'hcf));
        run_one(32'h0041_2344, acc_inst, priv_s, 1'b0);
        run_one(32'h0041_2344, acc_load, priv_s, 1'b0);
        run_one(32'h0041_2344, acc_store, priv_s, 1'b0);
        run_one(32'h0080_3abc, acc_inst, priv_s, 1'b0);
        run_one(32'h0080_3abc, acc_load, priv_s, 1'b0);
        run_one(32'h0080_3abc, acc_store, priv_s, 1'b0);
    endtask

    task automatic perm_faults();
        map_word({root, 10'd4, 2'b00}, make_pte(22'h01000, 8'hce)); // V clear
        map_word({root, 10'd5, 2'b00}, make_pte(22'h01400, 8'hc9)); // no R
        map_word({root, 10'd6, 2'b00}, make_pte(22'h01800, 8'hc7)); // no X
        map_word({root, 10'd7, 2'b00}, make_pte(22'h01c00, 8'h4f)); // dirty clear
        map_word({root, 10'd8, 2'b00}, make_pte(22'h02000, 8'h8f)); // accessed clear
        map_word({root, 10'd9, 2'b00}, make_pte(22'h02400, 8'hdf)); // user page
        run_one(32'h0100_0010, acc_load, priv_s, 1'b0);
        run_one(32'h0140_0020, acc_load, priv_s, 1'b0);
        run_one(32'h0180_0030, acc_inst, priv_s, 1'b0);
        run_one(32'h01c0_0040, acc_store, priv_s, 1'b0);
        run_one(32'h0200_0050, acc_load, priv_s, 1'b0);
        run_one(32'h0240_0060, acc_load, priv_s, 1'b0);
        run_one(32'h0240_0060, acc_load, priv_s, 1'b1);
        run_one(32'h0040_0080, acc_load, priv_u, 1'b0); // supervisor page
    endtask

    task automatic bus_errors();
        err_en = 1'b1;
        err_addr = {root, 10'd11, 2'b00};
        map_word(err_addr, make_pte(22'h02800, 8'hcf));
        run_one(32'h02c0_0004, acc_load, priv_s, 1'b0);
        map_word({root, 10'd12, 2'b00}, make_pte(22'h00300, 8'h01));
        err_addr = {22'h00300, 10'd5, 2'b00}; // level 0 entry
        map_word(err_addr, make_pte(22'h03000, 8'hcf));
        run_one(32'h0300_5008, acc_inst, priv_s, 1'b0);
        err_en = 1'b0;
    endtask

    task automatic back_pressure();
        max_wait = 4'd3;
        fork
            begin
                send_req(32'h0041_2344, acc_load, priv_s, satp_sv32, 1'b0);
                send_req(32'h0080_3abc, acc_store, priv_s, satp_sv32, 1'b0);
                send_req(32'h0100_0010, acc_inst, priv_s, satp_sv32, 1'b0);
            end
            collect(3, 1'b1);
        join
        max_wait = 4'd0;
        resp_ready = 1'b1;
    endtask

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req_va = '0;
        req_access = acc_inst;
        req_priv = priv_s;
        satp = '0;
        sum = 1'b0;
        resp_ready = 1'b1;
        max_wait = 4'd0;
        err_en = 1'b0;
        err_addr = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (req_ready && !resp_valid && !psel && !penable) else begin
            $display("MISMATCH at %0t: after reset req_ready %b resp_valid %b psel %b penable %b",
                     $time, req_ready, resp_valid, psel, penable);
            abort_run();
        end
        @(posedge clk);
        #1;
        bare_mode();
        translate_ok();
        perm_faults();
        bus_errors();
        back_pressure();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== tb_pt_mem.sv ====
module tb_pt_mem #(
    parameter int pa_width = 34
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [pa_width-1:0] paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic [3:0]          max_wait,
    input  logic                err_en,
    input  logic [pa_width-1:0] err_addr
);

    logic [31:0] mem [logic [pa_width-1:0]]; // sparse, unmapped words read as zero
    logic [3:0]  wait_cnt;
    int          seed = 32'h950;

    task automatic put_word(input logic [pa_width-1:0] addr, input logic [31:0] data);
        mem[addr] = data;
    endtask

    function automatic logic [3:0] pick_wait();
        int r;
        int span;
        span = int'(max_wait) + 1;
        r = $random(seed) & 32'h7fff_ffff;
        return 4'(r % span);
    endfunction

    // ready once the wait count has run out
    assign pready = psel && penable && (wait_cnt == 4'd0);

    always @(posedge clk) begin
        if (rst) begin
            wait_cnt <= 4'd0;
            prdata   <= 32'h0;
            pslverr  <= 1'b0;
        end else if (psel && !penable) begin // setup phase
            wait_cnt <= pick_wait();
            prdata   <= mem.exists(paddr) ? mem[paddr] : 32'h0;
            pslverr  <= pwrite || (err_en && (paddr == err_addr)); // read-only slave
        end else if (psel && penable && wait_cnt != 4'd0) begin
            wait_cnt <= wait_cnt - 4'd1;
        end
    end

endmodule
